// File: testbench/system_stimulus.txt
# op address data sel expected, all hex; data RND is random, expected MEM is the RAM model
# write expects led_o or -, set-buttons data is btn_i, wait-for-irq data is a cycle limit
wait-for-irq 00000000 0 0 ffffffff
read e0020000 0 f 00000000
read e0020004 0 f 00000000
read e0020008 0 f 00000000
read e002000c 0 f 00000000
read e0020010 0 f 00000000
read e0020014 0 f 00000000
read e0040000 0 f 00000000
read e0040004 0 f 00000000
read e0040008 0 f 00000000
read e004000c 0 f 00000000
read e0040010 0 f 00000000
# RAM with full and partial byte selects, 1010 and 1018 wrap
write 00000010 RND f -
write 00000014 RND f -
write 00001018 RND f -
write 00000010 RND 3 -
write 00000014 RND c -
write 00000018 RND 5 -
read 00000010 0 f MEM
read 00000014 0 f MEM
read 00000018 0 f MEM
read 00001010 0 f MEM
# Unmapped region 7000
expect-error e0000010 ffffffff f -
expect-error e0000004 ffffffff f -
read 00000010 0 f MEM
read e0020004 0 f 00000000
read e0040004 0 f 00000000
# Timer channel 0 one-shot, then channel 1 with auto-reload
write e0020004 00000028 f -
write e0020000 00000005 1 -
wait-for-irq 00000000 2d 0 fffffffd
read e0020000 0 f 0000000c
write e0020000 00000008 1 -
wait-for-irq 00000000 2 0 ffffffff
write e0020010 00000028 f -
write e002000c 00000007 1 -
wait-for-irq 00000000 2d 0 fffffff7
read e002000c 0 f 0000000f
write e002000c 00000008 1 -
wait-for-irq 00000000 2 0 ffffffff
# GPIO outputs, masked and unmasked button edges
write e0040004 000000a5 f 000000a5
write e004000c 00000200 f -
set-buttons 00000000 2 0 -
wait-for-irq 00000000 8 0 fffffffb
read e0040010 0 f 00000200
set-buttons 00000000 4 0 -
read e004000c 0 f 00000200
read e0040010 0 f 00000200
set-buttons 00000000 0 0 -
write e0040010 00000200 f -
wait-for-irq 00000000 4 0 ffffffff
read e0040010 0 f 00000000
# Display value
write e0040004 00001234 f 00000034

// File: project.f
+incdir+testbench
source/soc_pkg.sv
source/wb_decoder.sv
source/wb_bram.sv
source/wb_timer.sv
source/wb_gpio.sv
source/gpio_sevenseg.sv
source/system.sv
testbench/tb_system.sv

// File: Makefile
# Verilator build and run of the system testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, log to $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_system -f project.f
	./obj_dir/Vtb_system 2>&1 | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: testbench/tb_checks.svh
// Error counters for the system testbench
// Typed compare tasks for read data, interrupts and the display

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Wrong values and other failures are counted apart
int value_errors    = 0;
int protocol_errors = 0;

// Bus read data and led snapshots
task automatic check_word(input string name, input soc_pkg::word_t exp,
		input soc_pkg::word_t act);
	if (act !== exp) begin
		value_errors++;
		$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
	end
endtask

// Whole active-low interrupt vector
task automatic check_irq(input string name, input soc_pkg::word_t exp,
		input soc_pkg::word_t act);
	if (act !== exp) begin
		value_errors++;
		$display("[FAIL] %s irq_n_o: expected %h, actual %h", name, exp, act);
	end
endtask

// Segment pattern of the digit that is lit
task automatic check_seg(input string name, input logic [6:0] exp, input logic [6:0] act);
	if (act !== exp) begin
		value_errors++;
		$display("[FAIL] %s seg_o: expected %h, actual %h", name, exp, act);
	end
endtask

// Handshake trouble, bad stimulus lines and the like
task automatic report_problem(input string what);
	protocol_errors++;
	$display("[ERROR] %s", what);
endtask

`endif

// File: testbench/tb_system.sv
// System testbench
// Clock and reset, stimulus file player with a RAM model,
// bus and display monitors, and the watchdog

module tb_system;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int    CLK_PERIOD     = 20;
	localparam int    RESET_CYCLES   = 10;
	localparam int    SEED           = 32'h797;
	localparam int    WATCHDOG_SLACK = 64;
	localparam int    ACK_LIMIT      = 16;
	localparam int    DISPLAY_LIMIT  = 4 * 2**soc_pkg::SEG_REFRESH_BITS;
	localparam string STIMULUS       = "testbench/system_stimulus.txt";

	// Hex glyphs, segment a in bit 0, a lit segment as 1
	localparam logic [6:0] GLYPHS [16] = '{
		7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
		7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
	};

	// One parsed line of the stimulus file
	typedef struct {
		string          op;
		soc_pkg::word_t adr;
		string          dat_tok;
		soc_pkg::sel_t  sel;
		string          exp_tok;
	} step_t;

	logic             clk;
	logic             reset_i;
	soc_pkg::wb_req_t bus_i;
	soc_pkg::wb_rsp_t bus_o;
	logic             err_o;
	logic [3:0]       btn_i;
	logic [7:0]       led_o;
	logic [6:0]       seg_o;
	logic [3:0]       an_o;
	soc_pkg::word_t   irq_n_o;

	// Reference state kept beside the DUT
	step_t          steps[$];
	soc_pkg::word_t ram_model [int];
	soc_pkg::word_t out_shadow = '0;
	logic [7:0]     led_snapshot;
	int             seed = SEED;
	int             watchdog_cycles = 0;

	// Display coverage since the last OUT change
	int         display_settle = 0;
	int         display_age    = 0;
	logic [3:0] display_seen   = '0;

	`include "tb_checks.svh"

	system u_system (
		.clk_i   (clk),
		.reset_i (reset_i),
		.bus_i   (bus_i),
		.bus_o   (bus_o),
		.err_o   (err_o),
		.btn_i   (btn_i),
		.led_o   (led_o),
		.seg_o   (seg_o),
		.an_o    (an_o),
		.irq_n_o (irq_n_o)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		reset_i = 1'b1;
		bus_i   = '0;
		btn_i   = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset_i <= 1'b0;
	end

	//------------------------------------------------------------------------
	// Helpers
	//------------------------------------------------------------------------
	// RAM word index, the RAM wraps above its depth
	function automatic int ram_key(input soc_pkg::word_t adr);
		return int'(adr[soc_pkg::BRAM_ADR_WIDTH+1:2]);
	endfunction

	function automatic logic hits_register(input soc_pkg::word_t adr,
			input logic [soc_pkg::REGION_BITS-1:0] region, input int offset);
		return adr[31:17] == region && int'(adr[4:2]) == offset;
	endfunction

	// TCR of any timer channel
	function automatic logic hits_tcr(input soc_pkg::word_t adr);
		logic hit;
		hit = 1'b0;
		for (int c = 0; c < soc_pkg::TIMER_CHANNELS; c++)
			if (hits_register(adr, soc_pkg::REGION_TIMER,
					c * soc_pkg::TIMER_CH_STRIDE + soc_pkg::TIMER_TCR))
				hit = 1'b1;
		return hit;
	endfunction

	// Hex value, or the modelled RAM word for MEM
	function automatic soc_pkg::word_t expected_value(input step_t st);
		soc_pkg::word_t v;
		v = 'x;
		if (st.exp_tok == "MEM") begin
			if (ram_model.exists(ram_key(st.adr)))
				v = ram_model[ram_key(st.adr)];
		end else begin
			void'($sscanf(st.exp_tok, "%h", v));
		end
		return v;
	endfunction

	// Merge selected bytes into the RAM model and the OUT shadow
	task automatic note_write(input soc_pkg::word_t adr, input soc_pkg::word_t dat,
			input soc_pkg::sel_t sel);
		soc_pkg::word_t old;
		if (adr[31:17] == soc_pkg::REGION_BRAM) begin
			old = ram_model.exists(ram_key(adr)) ? ram_model[ram_key(adr)] : 'x;
			for (int b = 0; b < 4; b++)
				if (sel[b])
					old[8*b +: 8] = dat[8*b +: 8];
			ram_model[ram_key(adr)] = old;
		end
		if (hits_register(adr, soc_pkg::REGION_GPIO, soc_pkg::GPIO_OUT)) begin
			for (int b = 0; b < 4; b++)
				if (sel[b])
					out_shadow[8*b +: 8] = dat[8*b +: 8];
			// Segments follow one register stage later
			display_settle = 2;
			display_seen   = '0;
			display_age    = 0;
		end
	endtask

	// One Wishbone classic cycle, ends with the strobe dropped
	task automatic run_cycle(input soc_pkg::word_t adr, input soc_pkg::word_t dat,
			input soc_pkg::sel_t sel, input logic we, input string name,
			output soc_pkg::word_t rdata, output logic acked, output logic erred);
		soc_pkg::wb_req_t req;
		int               waited;
		req     = '0;
		req.adr = adr;
		req.dat = dat;
		req.sel = sel;
		req.we  = we;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		@(posedge clk);
		bus_i <= req;
		acked  = 1'b0;
		erred  = 1'b0;
		rdata  = '0;
		waited = 0;
		while (!acked && !erred && waited < ACK_LIMIT) begin
			@(negedge clk);
			acked        = bus_o.ack;
			erred        = err_o;
			rdata        = bus_o.dat;
			led_snapshot = led_o;
			waited++;
		end
		if (!acked && !erred)
			report_problem($sformatf("%s: no ack or err within %0d cycles", name, ACK_LIMIT));
		@(posedge clk);
		bus_i <= '0;
	endtask

	// Stopped channel keeps the written EN, AR and IRQEN, TRIG reads clear
	task automatic verify_trig_cleared(input string name, input soc_pkg::word_t adr,
			input soc_pkg::word_t dat);
		soc_pkg::word_t exp;
		soc_pkg::word_t rdata;
		logic           acked;
		logic           erred;
		exp                     = '0;
		exp[soc_pkg::TCR_EN]    = dat[soc_pkg::TCR_EN];
		exp[soc_pkg::TCR_AR]    = dat[soc_pkg::TCR_AR];
		exp[soc_pkg::TCR_IRQEN] = dat[soc_pkg::TCR_IRQEN];
		run_cycle(adr, '0, 4'hf, 1'b0, name, rdata, acked, erred);
		if (erred)
			report_problem({name, ": err on the TCR readback"});
		else if (acked)
			check_word({name, " TCR readback"}, exp, rdata);
	endtask

	// Poll the vector until it matches or the limit runs out
	task automatic wait_irq(input string name, input int limit, input soc_pkg::word_t exp);
		int waited;
		waited = 0;
		@(negedge clk);
		while (irq_n_o !== exp && waited < limit) begin
			@(negedge clk);
			waited++;
		end
		check_irq(name, exp, irq_n_o);
	endtask

	//------------------------------------------------------------------------
	// Stimulus file
	//------------------------------------------------------------------------
	task automatic load_steps();
		int             fd;
		int             code;
		string          tok;
		string          rest;
		soc_pkg::word_t adr;
		soc_pkg::sel_t  sel;
		step_t          st;
		fd = $fopen(STIMULUS, "r");
		if (fd == 0) begin
			report_problem({"cannot open ", STIMULUS});
			return;
		end
		while (!$feof(fd)) begin
			code = $fscanf(fd, "%s", tok);
			if (code != 1)
				break;
			if (tok.substr(0, 0) == "#") begin
				code = $fgets(rest, fd);
			end else begin
				st.op = tok;
				code  = $fscanf(fd, "%h %s %h %s", adr, st.dat_tok, sel, st.exp_tok);
				st.adr = adr;
				st.sel = sel;
				if (code != 4)
					report_problem({"malformed stimulus line for ", tok});
				else
					steps.push_back(st);
			end
		end
		$fclose(fd);
	endtask

	task automatic run_step(input int index, input step_t st);
		string          name;
		soc_pkg::word_t data;
		soc_pkg::word_t rdata;
		logic           acked;
		logic           erred;
		name = $sformatf("step %0d %s %h", index, st.op, st.adr);
		data = '0;
		if (st.dat_tok == "RND")
			data = $random(seed);
		else
			void'($sscanf(st.dat_tok, "%h", data));
		if (st.op == "write") begin
			run_cycle(st.adr, data, st.sel, 1'b1, name, rdata, acked, erred);
			if (erred) begin
				report_problem({name, ": err where ack was expected"});
			end else if (acked) begin
				note_write(st.adr, data, st.sel);
				if (st.exp_tok != "-")
					check_word({name, " led_o"}, expected_value(st), {24'd0, led_snapshot});
				if (hits_tcr(st.adr) && st.sel[0] && data[soc_pkg::TCR_TRIG]
						&& !data[soc_pkg::TCR_EN])
					verify_trig_cleared(name, st.adr, data);
			end
		end else if (st.op == "read") begin
			run_cycle(st.adr, '0, st.sel, 1'b0, name, rdata, acked, erred);
			if (erred)
				report_problem({name, ": err where ack was expected"});
			else if (acked)
				check_word(name, expected_value(st), rdata);
		end else if (st.op == "expect-error") begin
			run_cycle(st.adr, data, st.sel, 1'b1, name, rdata, acked, erred);
			if (acked)
				report_problem({name, ": ack where err was expected"});
		end else if (st.op == "set-buttons") begin
			@(posedge clk);
			btn_i <= data[3:0];
		end else if (st.op == "wait-for-irq") begin
			wait_irq(name, int'(data), expected_value(st));
		end else begin
			report_problem({name, ": unknown operation"});
		end
	endtask

	initial begin : player
		int             max_compare;
		soc_pkg::word_t cmp;
		load_steps();
		// Largest COMPARE sets the watchdog budget
		max_compare = 0;
		foreach (steps[i]) begin
			for (int c = 0; c < soc_pkg::TIMER_CHANNELS; c++) begin
				if (steps[i].op == "write" && steps[i].dat_tok != "RND" &&
						hits_register(steps[i].adr, soc_pkg::REGION_TIMER,
						c * soc_pkg::TIMER_CH_STRIDE + soc_pkg::TIMER_COMPARE)) begin
					void'($sscanf(steps[i].dat_tok, "%h", cmp));
					if (int'(cmp) > max_compare)
						max_compare = int'(cmp);
				end
			end
		end
		watchdog_cycles = steps.size() * 8 + max_compare + 4 * DISPLAY_LIMIT
			+ RESET_CYCLES + WATCHDOG_SLACK;
		wait (reset_i == 1'b0);
		@(posedge clk);
		foreach (steps[i])
			run_step(i, steps[i]);
		// Let the display show every digit of the last OUT value
		while (display_seen != 4'hf && display_age < DISPLAY_LIMIT)
			@(posedge clk);
		repeat (2) @(posedge clk);
		$display("Errors: %0d wrong values, %0d other failures", value_errors, protocol_errors);
		if (value_errors + protocol_errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	//------------------------------------------------------------------------
	// Monitors and watchdog
	//------------------------------------------------------------------------
	// Responses only while a request is on the bus
	always @(negedge clk) begin
		if (reset_i === 1'b0 && (bus_o.ack || err_o) && !(bus_i.cyc && bus_i.stb))
			report_problem("ack or err seen with no request on the bus");
	end

	// Lit digit must carry the glyph of its nibble
	always @(negedge clk) begin
		if (reset_i !== 1'b0) begin
			display_age = 0;
		end else if (display_settle > 0) begin
			display_settle--;
		end else begin
			for (int k = 0; k < 4; k++) begin
				if (!an_o[k]) begin
					check_seg($sformatf("digit %0d", k), ~GLYPHS[out_shadow[4*k +: 4]], seg_o);
					display_seen[k] = 1'b1;
				end
			end
			if (display_seen != 4'hf) begin
				display_age++;
				if (display_age == DISPLAY_LIMIT)
					report_problem($sformatf("display did not show all digits in %0d cycles",
						DISPLAY_LIMIT));
			end
		end
	end

	initial begin : watchdog
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
		$display("Errors: %0d wrong values, %0d other failures", value_errors, protocol_errors);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: source/system.sv
// Peripheral system top level
// Address decoder, block RAM, timer, GPIO, seven-segment
// display and the active-low interrupt vector

module system (
	input  logic             clk_i,
	input  logic             reset_i,
	input  soc_pkg::wb_req_t bus_i,
	output soc_pkg::wb_rsp_t bus_o,
	output logic             err_o,
	input  logic [3:0]       btn_i,
	output logic [7:0]       led_o,
	output logic [6:0]       seg_o,
	output logic [3:0]       an_o,
	output soc_pkg::word_t   irq_n_o
);

	soc_pkg::wb_req_t [soc_pkg::SLAVE_COUNT-1:0] slave_req;
	soc_pkg::wb_rsp_t [soc_pkg::SLAVE_COUNT-1:0] slave_rsp;

	logic [soc_pkg::TIMER_CHANNELS-1:0] timer_intr;
	logic                               gpio_intr;
	soc_pkg::word_t                     gpio_in;
	soc_pkg::word_t                     gpio_out;
	soc_pkg::word_t                     irq;

	//------------------------------------------------------------------------
	// Interconnect
	//------------------------------------------------------------------------
	wb_decoder u_decoder (
		.clk_i       (clk_i),
		.reset_i     (reset_i),
		.bus_i       (bus_i),
		.bus_o       (bus_o),
		.err_o       (err_o),
		.slave_req_o (slave_req),
		.slave_rsp_i (slave_rsp)
	);

	//------------------------------------------------------------------------
	// Slaves
	//------------------------------------------------------------------------
	wb_bram #(
		.adr_width (soc_pkg::BRAM_ADR_WIDTH)
	) u_bram (
		.clk_i   (clk_i),
		.reset_i (reset_i),
		.req_i   (slave_req[soc_pkg::SLAVE_BRAM]),
		.rsp_o   (slave_rsp[soc_pkg::SLAVE_BRAM])
	);

	wb_timer u_timer (
		.clk_i   (clk_i),
		.reset_i (reset_i),
		.req_i   (slave_req[soc_pkg::SLAVE_TIMER]),
		.rsp_o   (slave_rsp[soc_pkg::SLAVE_TIMER]),
		.intr_o  (timer_intr)
	);

	// Buttons land on GPIO inputs 11:8
	assign gpio_in = {20'd0, btn_i, 8'd0};

	wb_gpio u_gpio (
		.clk_i     (clk_i),
		.reset_i   (reset_i),
		.req_i     (slave_req[soc_pkg::SLAVE_GPIO]),
		.rsp_o     (slave_rsp[soc_pkg::SLAVE_GPIO]),
		.gpio_i    (gpio_in),
		.gpio_o    (gpio_out),
		.gpio_oe_o (),
		.intr_o    (gpio_intr)
	);

	// Display shows the low half of the GPIO outputs
	gpio_sevenseg u_sevenseg (
		.clk_i   (clk_i),
		.reset_i (reset_i),
		.value_i (gpio_out[15:0]),
		.seg_o   (seg_o),
		.an_o    (an_o)
	);

	assign led_o = gpio_out[7:0];

	// Interrupt vector, unused lines stay inactive
	always_comb begin
		irq                       = '0;
		irq[soc_pkg::IRQ_UART]    = 1'b0;
		irq[soc_pkg::IRQ_TIMER0]  = timer_intr[0];
		irq[soc_pkg::IRQ_GPIO]    = gpio_intr;
		irq[soc_pkg::IRQ_TIMER1]  = timer_intr[1];
	end

	assign irq_n_o = ~irq;

endmodule

// File: source/gpio_sevenseg.sv
// Four-digit seven-segment display driver
// Time-multiplexed hex digits, anodes and segments active low

module gpio_sevenseg (
	input  logic        clk_i,
	input  logic        reset_i,
	input  logic [15:0] value_i,
	output logic [6:0]  seg_o,
	output logic [3:0]  an_o
);

	// Two extra bits above the refresh period select the digit
	logic [soc_pkg::SEG_REFRESH_BITS+1:0] refresh_q;
	logic [1:0]                           digit;

	// Hex glyph, bit 0 is segment a, bit 6 is segment g
	function automatic logic [6:0] glyph(logic [3:0] nibble);
		logic [6:0] lit;
		case (nibble)
			4'h0: lit = 7'h3f;
			4'h1: lit = 7'h06;
			4'h2: lit = 7'h5b;
			4'h3: lit = 7'h4f;
			4'h4: lit = 7'h66;
			4'h5: lit = 7'h6d;
			4'h6: lit = 7'h7d;
			4'h7: lit = 7'h07;
			4'h8: lit = 7'h7f;
			4'h9: lit = 7'h6f;
			4'ha: lit = 7'h77;
			4'hb: lit = 7'h7c;
			4'hc: lit = 7'h39;
			4'hd: lit = 7'h5e;
			4'he: lit = 7'h79;
			default: lit = 7'h71;
		endcase
		// Board segments are active low
		return ~lit;
	endfunction

	assign digit = refresh_q[soc_pkg::SEG_REFRESH_BITS+1:soc_pkg::SEG_REFRESH_BITS];

	// Anode and glyph registered together so they never disagree
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			refresh_q <= '0;
			an_o      <= 4'hf;
			seg_o     <= 7'h7f;
		end else begin
			refresh_q <= refresh_q + 1'b1;
			an_o      <= ~(4'b0001 << digit);
			seg_o     <= glyph(value_i[4*digit +: 4]);
		end
	end

endmodule

// File: source/wb_gpio.sv
// Wishbone GPIO block
// IN, OUT, OE, MASK and PENDING registers, two-flop input
// synchroniser and masked rising-edge interrupts

module wb_gpio (
	input  logic             clk_i,
	input  logic             reset_i,
	input  soc_pkg::wb_req_t req_i,
	output soc_pkg::wb_rsp_t rsp_o,
	input  soc_pkg::word_t   gpio_i,
	output soc_pkg::word_t   gpio_o,
	output soc_pkg::word_t   gpio_oe_o,
	output logic             intr_o
);

	logic [soc_pkg::REG_OFFSET_BITS-1:0] offset;
	logic           access;
	logic           wr;
	logic           ack_q;
	soc_pkg::word_t wmask;
	soc_pkg::word_t rdata;
	soc_pkg::word_t dat_q;

	// Input pipe and edge detect
	soc_pkg::word_t sync1_q;
	soc_pkg::word_t sync2_q;
	soc_pkg::word_t prev_q;
	soc_pkg::word_t rise;

	// Registers
	soc_pkg::word_t out_q;
	soc_pkg::word_t oe_q;
	soc_pkg::word_t mask_q;
	soc_pkg::word_t pending_q;
	soc_pkg::word_t clear;

	assign offset = req_i.adr[soc_pkg::REG_OFFSET_BITS+1:2];
	assign access = req_i.cyc & req_i.stb & ~ack_q;
	assign wr     = access & req_i.we;
	assign wmask  = soc_pkg::sel_mask(req_i.sel);
	assign rise   = sync2_q & ~prev_q;

	// Write-one-to-clear on PENDING
	assign clear = (wr && offset == soc_pkg::GPIO_PENDING) ? (req_i.dat & wmask) : '0;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			sync1_q   <= '0;
			sync2_q   <= '0;
			prev_q    <= '0;
			out_q     <= '0;
			oe_q      <= '0;
			mask_q    <= '0;
			pending_q <= '0;
			ack_q     <= 1'b0;
		end else begin
			sync1_q <= gpio_i;
			sync2_q <= sync1_q;
			prev_q  <= sync2_q;
			ack_q   <= access;
			// A new edge beats a clear in the same cycle
			pending_q <= (pending_q & ~clear) | (rise & mask_q);
			if (wr && offset == soc_pkg::GPIO_OUT)
				out_q <= (out_q & ~wmask) | (req_i.dat & wmask);
			if (wr && offset == soc_pkg::GPIO_OE)
				oe_q <= (oe_q & ~wmask) | (req_i.dat & wmask);
			if (wr && offset == soc_pkg::GPIO_MASK)
				mask_q <= (mask_q & ~wmask) | (req_i.dat & wmask);
		end
	end

	// Read mux, IN shows the synchronised pins
	always_comb begin
		case (offset)
			soc_pkg::GPIO_IN:      rdata = sync2_q;
			soc_pkg::GPIO_OUT:     rdata = out_q;
			soc_pkg::GPIO_OE:      rdata = oe_q;
			soc_pkg::GPIO_MASK:    rdata = mask_q;
			soc_pkg::GPIO_PENDING: rdata = pending_q;
			default:               rdata = '0;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (access)
			dat_q <= rdata;
	end

	assign rsp_o.dat = dat_q;
	assign rsp_o.ack = ack_q;
	assign gpio_o    = out_q;
	assign gpio_oe_o = oe_q;
	assign intr_o    = |pending_q;

endmodule

// File: source/wb_timer.sv
// Wishbone timer with two compare channels
// Per channel TCR, COMPARE and COUNTER, auto-reload and a
// sticky TRIG flag that drives the interrupt when enabled

module wb_timer (
	input  logic                                clk_i,
	input  logic                                reset_i,
	input  soc_pkg::wb_req_t                    req_i,
	output soc_pkg::wb_rsp_t                    rsp_o,
	output logic [soc_pkg::TIMER_CHANNELS-1:0]  intr_o
);

	localparam int CH = soc_pkg::TIMER_CHANNELS;

	logic [soc_pkg::REG_OFFSET_BITS-1:0] offset;
	logic                                access;
	logic                                wr;
	logic                                ack_q;
	soc_pkg::word_t                      wmask;
	soc_pkg::word_t                      rdata;
	soc_pkg::word_t                      dat_q;

	// Channel state
	logic [CH-1:0]  en_q;
	logic [CH-1:0]  ar_q;
	logic [CH-1:0]  irqen_q;
	logic [CH-1:0]  trig_q;
	soc_pkg::word_t compare_q [CH];
	soc_pkg::word_t counter_q [CH];

	assign offset = req_i.adr[soc_pkg::REG_OFFSET_BITS+1:2];
	assign access = req_i.cyc & req_i.stb & ~ack_q;
	assign wr     = access & req_i.we;
	assign wmask  = soc_pkg::sel_mask(req_i.sel);

	//------------------------------------------------------------------------
	// Counters and register writes
	//------------------------------------------------------------------------
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			en_q    <= '0;
			ar_q    <= '0;
			irqen_q <= '0;
			trig_q  <= '0;
			ack_q   <= 1'b0;
			for (int c = 0; c < CH; c++) begin
				compare_q[c] <= '0;
				counter_q[c] <= '0;
			end
		end else begin
			ack_q <= access;
			for (int c = 0; c < CH; c++) begin
				// Match restarts from zero, one-shot stops here
				if (en_q[c]) begin
					if (counter_q[c] == compare_q[c]) begin
						trig_q[c]    <= 1'b1;
						counter_q[c] <= '0;
						if (!ar_q[c])
							en_q[c] <= 1'b0;
					end else begin
						counter_q[c] <= counter_q[c] + 32'd1;
					end
				end
				// Bus writes take priority over the count
				if (wr && int'(offset) == c*soc_pkg::TIMER_CH_STRIDE + soc_pkg::TIMER_TCR
						&& req_i.sel[0]) begin
					en_q[c]    <= req_i.dat[soc_pkg::TCR_EN];
					ar_q[c]    <= req_i.dat[soc_pkg::TCR_AR];
					irqen_q[c] <= req_i.dat[soc_pkg::TCR_IRQEN];
					// TRIG is write-one-to-clear
					if (req_i.dat[soc_pkg::TCR_TRIG])
						trig_q[c] <= 1'b0;
				end
				if (wr && int'(offset) == c*soc_pkg::TIMER_CH_STRIDE + soc_pkg::TIMER_COMPARE)
					compare_q[c] <= (compare_q[c] & ~wmask) | (req_i.dat & wmask);
				if (wr && int'(offset) == c*soc_pkg::TIMER_CH_STRIDE + soc_pkg::TIMER_COUNTER)
					counter_q[c] <= (counter_q[c] & ~wmask) | (req_i.dat & wmask);
			end
		end
	end

	//------------------------------------------------------------------------
	// Read path
	//------------------------------------------------------------------------
	always_comb begin
		rdata = '0;
		for (int c = 0; c < CH; c++) begin
			if (int'(offset) == c*soc_pkg::TIMER_CH_STRIDE + soc_pkg::TIMER_TCR)
				rdata = {28'd0, trig_q[c], irqen_q[c], ar_q[c], en_q[c]};
			if (int'(offset) == c*soc_pkg::TIMER_CH_STRIDE + soc_pkg::TIMER_COMPARE)
				rdata = compare_q[c];
			if (int'(offset) == c*soc_pkg::TIMER_CH_STRIDE + soc_pkg::TIMER_COUNTER)
				rdata = counter_q[c];
		end
	end

	// Read word captured with the access
	always_ff @(posedge clk_i) begin
		if (access)
			dat_q <= rdata;
	end

	assign rsp_o.dat = dat_q;
	assign rsp_o.ack = ack_q;
	assign intr_o    = trig_q & irqen_q;

	// Counter stays within the compare window while running
	for (genvar c = 0; c < CH; c++) begin : g_chk
		a_count_range: assert property (@(posedge clk_i) disable iff (reset_i)
			(en_q[c] && compare_q[c] != '0) |-> (counter_q[c] <= compare_q[c]));
	end

endmodule

// File: source/wb_bram.sv
// Wishbone block RAM, one word wide
// Byte-select writes and a registered read word

module wb_bram #(
	parameter int adr_width = 10
) (
	input  logic             clk_i,
	input  logic             reset_i,
	input  soc_pkg::wb_req_t req_i,
	output soc_pkg::wb_rsp_t rsp_o
);

	soc_pkg::word_t         mem [2**adr_width];
	soc_pkg::word_t         dat_q;
	logic [adr_width-1:0]   word_adr;
	logic                   access;
	logic                   ack_q;

	// Word address, upper bits dropped so the RAM wraps
	assign word_adr = req_i.adr[adr_width+1:2];
	assign access   = req_i.cyc & req_i.stb & ~ack_q;

	always_ff @(posedge clk_i) begin
		if (reset_i)
			ack_q <= 1'b0;
		else
			ack_q <= access;
	end

	// Storage and read port
	always_ff @(posedge clk_i) begin
		if (access) begin
			for (int b = 0; b < 4; b++) begin
				if (req_i.we && req_i.sel[b])
					mem[word_adr][8*b +: 8] <= req_i.dat[8*b +: 8];
			end
			dat_q <= mem[word_adr];
		end
	end

	assign rsp_o.dat = dat_q;
	assign rsp_o.ack = ack_q;

	// Held request must not retrigger
	a_single_ack: assert property (@(posedge clk_i) disable iff (reset_i)
		ack_q |=> !ack_q);

endmodule

// File: source/wb_decoder.sv
// Wishbone address decoder for one master and the mapped slaves
// Region compare, per-slave cyc/stb gating, response mux
// and the error answer for unmapped addresses

module wb_decoder (
	input  logic                                           clk_i,
	input  logic                                           reset_i,
	input  soc_pkg::wb_req_t                               bus_i,
	output soc_pkg::wb_rsp_t                               bus_o,
	output logic                                           err_o,
	output soc_pkg::wb_req_t [soc_pkg::SLAVE_COUNT-1:0]    slave_req_o,
	input  soc_pkg::wb_rsp_t [soc_pkg::SLAVE_COUNT-1:0]    slave_rsp_i
);

	logic [soc_pkg::REGION_BITS-1:0] region;
	logic [soc_pkg::SLAVE_COUNT-1:0] hit;
	logic [soc_pkg::SLAVE_COUNT-1:0] ack_vec;
	logic                            unmapped;
	logic                            err_q;

	//------------------------------------------------------------------------
	// Region decode
	//------------------------------------------------------------------------
	// Upper address bits pick the slave
	assign region = bus_i.adr[31:32-soc_pkg::REGION_BITS];

	assign hit[soc_pkg::SLAVE_BRAM]  = (region == soc_pkg::REGION_BRAM);
	assign hit[soc_pkg::SLAVE_TIMER] = (region == soc_pkg::REGION_TIMER);
	assign hit[soc_pkg::SLAVE_GPIO]  = (region == soc_pkg::REGION_GPIO);
	assign unmapped = ~|hit;

	// Same request to all slaves, strobes only where the region matches
	always_comb begin
		for (int s = 0; s < soc_pkg::SLAVE_COUNT; s++) begin
			slave_req_o[s]     = bus_i;
			slave_req_o[s].cyc = bus_i.cyc & hit[s];
			slave_req_o[s].stb = bus_i.stb & hit[s];
		end
	end

	// Response of the addressed slave
	always_comb begin
		bus_o = '0;
		for (int s = 0; s < soc_pkg::SLAVE_COUNT; s++) begin
			ack_vec[s] = slave_rsp_i[s].ack;
			if (hit[s])
				bus_o = slave_rsp_i[s];
		end
	end

	//------------------------------------------------------------------------
	// Unmapped access
	//------------------------------------------------------------------------
	// One-cycle err, same latency as a slave ack
	always_ff @(posedge clk_i) begin
		if (reset_i)
			err_q <= 1'b0;
		else
			err_q <= bus_i.cyc & bus_i.stb & unmapped & ~err_q;
	end

	assign err_o = err_q;

	// Only the addressed slave may answer
	a_one_ack: assert property (@(posedge clk_i) disable iff (reset_i)
		$onehot0(ack_vec));

	// Master never sees both terminations
	a_ack_err: assert property (@(posedge clk_i) disable iff (reset_i)
		!(bus_o.ack && err_o));

endmodule

// File: source/soc_pkg.sv
// Shared definitions for the peripheral system
// Bus word and request/response structs, address map,
// register offsets and interrupt vector positions

package soc_pkg;

	// Bus types
	typedef logic [31:0] word_t;
	typedef logic [3:0]  sel_t;

	// Master request, held steady until ack or err
	typedef struct packed {
		word_t adr;
		word_t dat;
		sel_t  sel;
		logic  we;
		logic  cyc;
		logic  stb;
	} wb_req_t;

	// Slave response
	typedef struct packed {
		word_t dat;
		logic  ack;
	} wb_rsp_t;

	//------------------------------------------------------------------------
	// Address map
	//------------------------------------------------------------------------
	localparam int SLAVE_COUNT = 3;
	localparam int REGION_BITS = 15;

	// Slave slots on the decoder
	localparam int SLAVE_BRAM  = 0;
	localparam int SLAVE_TIMER = 1;
	localparam int SLAVE_GPIO  = 2;

	// Compared against adr[31:17]
	localparam logic [REGION_BITS-1:0] REGION_BRAM  = 15'h0000;
	localparam logic [REGION_BITS-1:0] REGION_TIMER = 15'h7001;
	localparam logic [REGION_BITS-1:0] REGION_GPIO  = 15'h7002;

	localparam int BRAM_ADR_WIDTH = 10;

	// Word offset field of a register address, adr[4:2]
	localparam int REG_OFFSET_BITS = 3;

	//------------------------------------------------------------------------
	// Timer registers
	//------------------------------------------------------------------------
	localparam int TIMER_CHANNELS  = 2;
	localparam int TIMER_TCR       = 0;
	localparam int TIMER_COMPARE   = 1;
	localparam int TIMER_COUNTER   = 2;
	localparam int TIMER_CH_STRIDE = 3;

	// TCR bits
	localparam int TCR_EN    = 0;
	localparam int TCR_AR    = 1;
	localparam int TCR_IRQEN = 2;
	localparam int TCR_TRIG  = 3;

	// GPIO registers
	localparam int GPIO_IN      = 0;
	localparam int GPIO_OUT     = 1;
	localparam int GPIO_OE      = 2;
	localparam int GPIO_MASK    = 3;
	localparam int GPIO_PENDING = 4;

	// Interrupt vector positions
	localparam int IRQ_UART   = 0;
	localparam int IRQ_TIMER0 = 1;
	localparam int IRQ_GPIO   = 2;
	localparam int IRQ_TIMER1 = 3;

	localparam int SEG_REFRESH_BITS = 8;

	// Byte selects widened to a bit mask
	function automatic word_t sel_mask(sel_t sel);
		return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
	endfunction

endpackage
